/* harvard_bus.f */
logic/bus_pkg.sv
logic/byte_lane_align.sv
logic/bus_controller.sv
logic/avalon_ram.sv
logic/harvard_bus_top.sv
tests/tb_clock_gen.sv
tests/harvard_bus_tb.sv

/* logic/avalon_ram.sv */
module avalon_ram #(
  parameter int WAIT_STATES = 2,
  parameter int MEM_WORDS   = 256
) (
  input  logic                 clk,
  input  logic                 reset,
  input  bus_pkg::avalon_req_t av_req,
  output logic                 waitrequest,
  output bus_pkg::word_t       readdata
);

  import bus_pkg::*;

  localparam int CNT_W  = $clog2(WAIT_STATES + 1);
  localparam int ADDR_W = $clog2(MEM_WORDS);

  word_t mem [MEM_WORDS];

  logic [CNT_W-1:0]  wait_cnt;   // cycles this request has been held
  logic [ADDR_W-1:0] word_index;
  logic              req_active;
  logic              accept;     // completion cycle

  assign req_active = av_req.read || av_req.write;

  // word address wraps around the array
  assign word_index = ADDR_W'((av_req.address / BYTES_PER_WORD) % MEM_WORDS);

  // waits until the request has been held WAIT_STATES cycles
  assign accept      = req_active && (wait_cnt == CNT_W'(WAIT_STATES));
  assign waitrequest = !accept;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wait_cnt <= '0;
    end
    else if (!req_active || accept)
    begin
      wait_cnt <= '0;  // ready for the next request
    end
    else
    begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // byte-lane write in the completion cycle
  always_ff @(posedge clk)
  begin
    if (accept && av_req.write)
    begin
      for (int b = 0; b < BYTES_PER_WORD; b++)
      begin
        if (av_req.byteenable[b])
        begin
          mem[word_index][b*BYTE_WIDTH +: BYTE_WIDTH] <=
            av_req.writedata[b*BYTE_WIDTH +: BYTE_WIDTH];
        end
      end
    end
  end

  // registered read, captured during the wait cycles
  // the address is steady, so the word is ready when waitrequest drops
  always_ff @(posedge clk)
  begin
    if (req_active)
    begin
      readdata <= mem[word_index];
    end
  end

  // a completion always follows a cycle holding the same request,
  // which is what the registered read path depends on
  assert property (@(posedge clk) disable iff (reset)
    !waitrequest |-> $past(req_active) && ($past(av_req) == av_req));

  // at least one wait state per access
  assert property (@(posedge clk) WAIT_STATES >= 1);

endmodule

/* logic/bus_controller.sv */
module bus_controller (
  input  logic                 clk,
  input  logic                 reset,
  input  bus_pkg::word_t       instr_address,
  input  logic                 instr_read,
  output bus_pkg::word_t       instr_readdata,
  input  bus_pkg::data_port_t  data_req,
  output bus_pkg::word_t       data_readdata,
  output logic                 clk_enable,
  output bus_pkg::avalon_req_t av_req,
  input  logic                 waitrequest,
  input  bus_pkg::word_t       readdata
);

  import bus_pkg::*;

  bus_state_t state;

  logic                      data_valid;  // exactly one of read and write
  logic [BYTES_PER_WORD-1:0] write_lanes;
  word_t                     write_shifted;
  word_t                     read_aligned;
  avalon_req_t               data_bus;
  avalon_req_t               instr_bus;

  assign data_valid = data_req.read ^ data_req.write;

  byte_lane_align u_align (
    .offset        (data_req.address[1:0]),
    .write_word    (data_req.writedata),
    .read_word     (readdata),
    .byteenable    (write_lanes),
    .shifted_write (write_shifted),
    .aligned_read  (read_aligned)
  );

  // data request, word aligned on the bus
  always_comb
  begin
    data_bus.address   = {data_req.address[ADDR_WIDTH-1:2], 2'b00};
    data_bus.read      = data_req.read;
    data_bus.write     = data_req.write;
    data_bus.writedata = data_req.write ? write_shifted : '0;
    // lanes only matter for writes, reads fetch the whole word
    data_bus.byteenable = data_req.write ? write_lanes : '1;
  end

  always_comb
  begin
    instr_bus.address    = instr_address;
    instr_bus.read       = 1'b1;
    instr_bus.write      = 1'b0;
    instr_bus.writedata  = '0;
    instr_bus.byteenable = '1;  // full word fetch
  end

  // bus request and stall per state
  always_comb
  begin
    av_req     = '0;
    clk_enable = 1'b0;
    case (state)
      IDLE:
      begin
        if (data_valid)
        begin
          av_req = data_bus;  // data goes first
        end
        else if (instr_read)
        begin
          av_req = instr_bus;
        end
        else
        begin
          clk_enable = 1'b1;  // nothing to do, let the cpu run
        end
      end
      FETCH_DATA:
      begin
        av_req = data_bus;
      end
      INSTR_SET, FETCH_INSTR:
      begin
        av_req = instr_bus;
      end
      default:
      begin
        clk_enable = 1'b1;  // HALTED, execution cycle
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state          <= IDLE;
      data_readdata  <= '0;
      instr_readdata <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (data_valid)
          begin
            state <= FETCH_DATA;
          end
          else if (instr_read)
          begin
            state <= FETCH_INSTR;
          end
        end
        FETCH_DATA:
        begin
          if (!waitrequest)
          begin
            state <= instr_read ? INSTR_SET : HALTED;
            if (data_req.read)
            begin
              data_readdata <= read_aligned;
            end
          end
        end
        INSTR_SET:
        begin
          state <= FETCH_INSTR;
        end
        FETCH_INSTR:
        begin
          if (!waitrequest)
          begin
            state          <= HALTED;
            instr_readdata <= readdata;
          end
        end
        default:
        begin
          state <= IDLE;  // back from the execution cycle
        end
      endcase
    end
  end

  // cpu must not ask for a data read and write at once
  assert property (@(posedge clk) disable iff (reset)
    !(data_req.read && data_req.write));

  // at most one transfer type on the bus
  assert property (@(posedge clk) disable iff (reset)
    !(av_req.read && av_req.write));

  // a stalled request is held until the slave accepts it
  assert property (@(posedge clk) disable iff (reset)
    (av_req.read || av_req.write) && waitrequest |=> $stable(av_req));

endmodule

/* logic/bus_pkg.sv */
package bus_pkg;

  // bus geometry
  localparam int ADDR_WIDTH     = 32;
  localparam int DATA_WIDTH     = 32;
  localparam int BYTE_WIDTH     = 8;
  localparam int BYTES_PER_WORD = DATA_WIDTH / BYTE_WIDTH;

  // one bus word
  typedef logic [DATA_WIDTH-1:0] word_t;

  // avalon-mm master request, 70 bits
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]     address;  // byte address, word aligned on the bus
    logic                      read;
    logic                      write;
    word_t                     writedata;
    logic [BYTES_PER_WORD-1:0] byteenable;
  } avalon_req_t;

  // cpu data port request, 66 bits
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] address;  // byte address, may be unaligned
    logic                  read;
    logic                  write;
    word_t                 writedata;
  } data_port_t;

  // controller states
  // cpu is stalled in every state except HALTED,
  // and in IDLE while a request is present
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    FETCH_DATA  = 3'd1,  // data read or write on the bus
    INSTR_SET   = 3'd2,  // instruction request after a data access
    FETCH_INSTR = 3'd3,  // instruction read on the bus
    HALTED      = 3'd4   // cpu execution cycle
  } bus_state_t;

endpackage

/* logic/byte_lane_align.sv */
module byte_lane_align (
  input  logic [1:0]                           offset,
  input  bus_pkg::word_t                       write_word,
  input  bus_pkg::word_t                       read_word,
  output logic [bus_pkg::BYTES_PER_WORD-1:0]   byteenable,
  output bus_pkg::word_t                       shifted_write,
  output bus_pkg::word_t                       aligned_read
);

  import bus_pkg::*;

  localparam int SHIFT_W = $clog2(DATA_WIDTH);

  // eight bits of shift per byte of offset
  logic [SHIFT_W-1:0] shift_bits;

  assign shift_bits = SHIFT_W'(offset) * SHIFT_W'(BYTE_WIDTH);

  // lanes from the offset byte up to the top of the word
  always_comb
  begin
    case (offset)
      2'd0:
      begin
        byteenable = 4'b1111;  // aligned whole word
      end
      2'd1:
      begin
        byteenable = 4'b1110;
      end
      2'd2:
      begin
        byteenable = 4'b1100;  // upper half
      end
      default:
      begin
        byteenable = 4'b1000;  // top byte only
      end
    endcase
  end

  // cpu data goes up into the addressed lanes
  assign shifted_write = write_word << shift_bits;

  // addressed byte comes back down to bit 0 with zero fill from the top
  assign aligned_read = read_word >> shift_bits;

endmodule

/* logic/harvard_bus_top.sv */
module harvard_bus_top #(
  parameter int WAIT_STATES = 2,
  parameter int MEM_WORDS   = 256
) (
  input  logic                clk,
  input  logic                reset,
  input  bus_pkg::word_t      instr_address,
  input  logic                instr_read,
  output bus_pkg::word_t      instr_readdata,
  input  bus_pkg::data_port_t data_req,
  output bus_pkg::word_t      data_readdata,
  output logic                clk_enable
);

  import bus_pkg::*;

  // avalon master to slave
  avalon_req_t av_req;
  logic        waitrequest;
  word_t       readdata;

  bus_controller u_controller (
    .clk            (clk),
    .reset          (reset),
    .instr_address  (instr_address),
    .instr_read     (instr_read),
    .instr_readdata (instr_readdata),
    .data_req       (data_req),
    .data_readdata  (data_readdata),
    .clk_enable     (clk_enable),
    .av_req         (av_req),
    .waitrequest    (waitrequest),
    .readdata       (readdata)
  );

  avalon_ram #(
    .WAIT_STATES (WAIT_STATES),
    .MEM_WORDS   (MEM_WORDS)
  ) u_ram (
    .clk         (clk),
    .reset       (reset),
    .av_req      (av_req),
    .waitrequest (waitrequest),
    .readdata    (readdata)
  );

endmodule

/* tests/bus_stimulus.mem */
// op daddr wdata iaddr exp_data exp_instr, one test per line
// op 1 instr read, 2 data read, 3 data write, 4 data read + instr read, 5 data write + instr read
// unused columns are zero
00000003 00000000 11223344 00000000 00000000 00000000
00000002 00000000 00000000 00000000 11223344 00000000
00000003 00000004 a5a55a5a 00000000 00000000 00000000
00000002 00000004 00000000 00000000 a5a55a5a 00000000
00000003 00000008 deadbeef 00000000 00000000 00000000
00000003 00000009 00c0ffee 00000000 00000000 00000000
00000002 00000008 00000000 00000000 c0ffeeef 00000000
00000003 0000000c 01234567 00000000 00000000 00000000
00000003 0000000e 0000beef 00000000 00000000 00000000
00000002 0000000c 00000000 00000000 beef4567 00000000
00000003 00000010 89abcdef 00000000 00000000 00000000
00000003 00000013 00000042 00000000 00000000 00000000
00000002 00000010 00000000 00000000 42abcdef 00000000
// unaligned reads, shifted down and zero filled
00000002 00000001 00000000 00000000 00112233 00000000
00000002 00000002 00000000 00000000 00001122 00000000
00000002 00000003 00000000 00000000 00000011 00000000
00000002 0000000d 00000000 00000000 00beef45 00000000
00000002 0000000a 00000000 00000000 0000c0ff 00000000
00000002 00000013 00000000 00000000 00000042 00000000
// instruction fetch only
00000001 00000000 00000000 00000000 00000000 11223344
00000001 00000000 00000000 00000004 00000000 a5a55a5a
00000001 00000000 00000000 00000010 00000000 42abcdef
// data access and instruction fetch in one stall
00000004 00000008 00000000 0000000c c0ffeeef beef4567
00000004 00000006 00000000 00000000 0000a5a5 11223344
00000005 00000014 13579bdf 00000008 00000000 c0ffeeef
00000004 00000014 00000000 00000014 13579bdf 13579bdf
00000005 00000015 000000aa 00000004 00000000 a5a55a5a
00000005 00000018 0f1e2d3c 00000018 00000000 0f1e2d3c
00000002 00000014 00000000 00000000 0000aadf 00000000
// addresses past the ram wrap around
00000002 00000410 00000000 00000000 42abcdef 00000000
00000003 0000041c cafef00d 00000000 00000000 00000000
00000001 00000000 00000000 0000001c 00000000 cafef00d
00000004 0000001f 00000000 0000001c 000000ca cafef00d
00000002 00000000 00000000 00000000 11223344 00000000

/* tests/harvard_bus_tb.sv */
module harvard_bus_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import bus_pkg::*;

  localparam int WAIT_STATES = 2;
  localparam int MEM_WORDS   = 256;
  localparam int MAX_TESTS   = 64;
  localparam int FIELDS      = 6;  // columns per test in the stimulus file

  logic       clk;
  logic       reset;
  word_t      instr_address;
  logic       instr_read;
  word_t      instr_readdata;
  data_port_t data_req;
  word_t      data_readdata;
  logic       clk_enable;

  word_t stim [MAX_TESTS*FIELDS];

  int num_tests;
  int checks;
  int errors;
  int cycle_count;
  int cycle_limit;
  int low_run;  // cycles of the current stall

  tb_clock_gen u_clock (
    .clk   (clk),
    .reset (reset)
  );

  harvard_bus_top #(
    .WAIT_STATES (WAIT_STATES),
    .MEM_WORDS   (MEM_WORDS)
  ) uut (
    .clk            (clk),
    .reset          (reset),
    .instr_address  (instr_address),
    .instr_read     (instr_read),
    .instr_readdata (instr_readdata),
    .data_req       (data_req),
    .data_readdata  (data_readdata),
    .clk_enable     (clk_enable)
  );

  // stall length, counted per rising edge
  always @(posedge clk)
  begin
    if (reset || clk_enable)
    begin
      low_run <= 0;
    end
    else
    begin
      low_run <= low_run + 1;
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
    begin
      $display("timeout after %0d cycles, the DUT never finished the tests", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  function automatic string op_name(input word_t op);
    case (op)
      32'd1:   return "instr read";
      32'd2:   return "data read";
      32'd3:   return "data write";
      32'd4:   return "data read + instr read";
      32'd5:   return "data write + instr read";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic release_request();
    instr_address = '0;
    instr_read    = 1'b0;
    data_req      = '0;
  endtask

  task automatic apply_request(input word_t op, input word_t daddr, input word_t wdata,
                               input word_t iaddr);
    release_request();
    data_req.address   = daddr;
    data_req.writedata = wdata;
    data_req.read      = (op == 2) || (op == 4);
    data_req.write     = (op == 3) || (op == 5);
    instr_address      = iaddr;
    instr_read         = (op == 1) || (op == 4) || (op == 5);
  endtask

  task automatic reset_state_test();
    int errors_before;
    errors_before = errors;
    @(negedge clk);
    check_value("reset clk_enable", 32'd1, {31'd0, clk_enable});
    check_value("reset data_readdata", 32'd0, data_readdata);
    check_value("reset instr_readdata", 32'd0, instr_readdata);
    $display("reset state: %s", (errors == errors_before) ? "pass" : "fail");
  endtask

  task automatic run_test(input int idx);
    word_t op;
    word_t daddr;
    word_t wdata;
    word_t iaddr;
    word_t exp_data;
    word_t exp_instr;
    int    expected_stall;
    int    errors_before;
    bit    saw_low;
    bit    done;
    string name;
    op        = stim[idx*FIELDS];
    daddr     = stim[idx*FIELDS+1];
    wdata     = stim[idx*FIELDS+2];
    iaddr     = stim[idx*FIELDS+3];
    exp_data  = stim[idx*FIELDS+4];
    exp_instr = stim[idx*FIELDS+5];
    name = $sformatf("test %0d %s", idx, op_name(op));
    errors_before = errors;
    if (op < 1 || op > 5)
    begin
      errors++;
      $display("test %0d has an unknown operation %0h in the stimulus file", idx, op);
    end
    else
    begin
      // one data or instr access takes the idle cycle plus the wait states,
      // both in one stall add the instr set cycle and a second wait
      expected_stall = (op >= 4) ? 2 * WAIT_STATES + 2 : WAIT_STATES + 1;
      @(negedge clk);
      apply_request(op, daddr, wdata, iaddr);
      saw_low = 1'b0;
      done    = 1'b0;
      while (!done)
      begin
        @(negedge clk);
        if (!clk_enable)
        begin
          saw_low = 1'b1;
        end
        else if (saw_low)
        begin
          done = 1'b1;  // execution cycle
        end
      end
      check_value({name, " stall cycles"}, expected_stall, low_run);
      if (op == 2 || op == 4)
      begin
        check_value({name, " data_readdata"}, exp_data, data_readdata);
      end
      if (op == 1 || op == 4 || op == 5)
      begin
        check_value({name, " instr_readdata"}, exp_instr, instr_readdata);
      end
      release_request();  // inputs change in the execution cycle
    end
    $display("%s: %s", name, (errors == errors_before) ? "pass" : "fail");
  endtask

  initial
  begin
    release_request();
    checks      = 0;
    errors      = 0;
    cycle_count = 0;
    cycle_limit = 0;
    for (int i = 0; i < MAX_TESTS * FIELDS; i++)
    begin
      stim[i] = '0;
    end
    $readmemh("tests/bus_stimulus.mem", stim);
    num_tests = 0;
    while (num_tests < MAX_TESTS && stim[num_tests*FIELDS] != '0)
    begin
      num_tests++;
    end
    cycle_limit = 10 + num_tests * (2 * WAIT_STATES + 4) + 50;
    @(negedge reset);
    reset_state_test();
    if (num_tests == 0)
    begin
      errors++;
      $display("no tests were found in the stimulus file");
    end
    for (int t = 0; t < num_tests; t++)
    begin
      run_test(t);
    end
    $display("tests run: %0d, checks: %0d, failures: %0d", num_tests + 1, checks, errors);
    if (errors == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;  // 40 ns period
  localparam int RESET_CYCLES = 10;

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  // released on a falling edge like every other DUT input
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule
